//--- ship_game.f
ship_pkg.sv
ps2_rx.sv
make_break_filter.sv
ship_motion.sv
raster_draw.sv
ship_game.sv
tb_ship_game.sv

//--- Bender.yml
package:
  name: ship_game

sources:
  - ship_pkg.sv
  - ps2_rx.sv
  - make_break_filter.sv
  - ship_motion.sv
  - raster_draw.sv
  - ship_game.sv
  - target: simulation
    files:
      - tb_ship_game.sv

//--- tb_ship_game.sv
// ship game testbench
`timescale 1ns/1ps

module tb_ship_game;

	localparam int frame_len = ship_pkg::screen_w * ship_pkg::screen_h; // clocks per frame
	localparam int half_bit  = 20; // system clocks per keyboard clock half period

	logic              clock;
	logic              reset;
	logic              ps2_clk;
	logic              ps2_data;
	ship_pkg::x_t      pixel_x;
	ship_pkg::y_t      pixel_y;
	ship_pkg::colour_t colour;
	logic              plot;

	integer seed = 32'hbcb7_ee9c;
	int errors;      // failed checks and timeouts
	int checks;
	int test_errors; // error count when the current test began
	int exp_x;       // expected ship position
	int exp_y;
	int white_count; // last scanned frame
	int white_x;
	int white_y;
	int plot_low;    // samples with plot low

	ship_game #(.FILTER_LEN(8), .START_X(8'd80), .START_Y(7'd60)) ship_game_inst (
		.clock    (clock),
		.reset    (reset),
		.ps2_clk  (ps2_clk),
		.ps2_data (ps2_data),
		.pixel_x  (pixel_x),
		.pixel_y  (pixel_y),
		.colour   (colour),
		.plot     (plot)
	);

	initial
	begin
		clock = 1'b0;
		forever #2 clock = ~clock; // 4 ns
	end

	task automatic check(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
		end
	endtask

	// one keyboard frame, lsb first
	task automatic send_byte(input ship_pkg::scan_code_t code);
		logic [10:0] frame;
		frame = {1'b1, ~^code, code, 1'b0}; // stop, odd parity, data, start
		for (int i = 0; i < 11; i++)
		begin
			@(posedge clock);
			ps2_data <= frame[i]; // data settles while clock is high
			repeat (half_bit) @(posedge clock);
			ps2_clk <= 1'b0;
			repeat (half_bit) @(posedge clock);
			ps2_clk <= 1'b1;
		end
		repeat (half_bit) @(posedge clock); // idle gap
	endtask

	// reference position update, clamped at the screen edges
	task automatic model_key(input ship_pkg::scan_code_t code);
		case (code)
			ship_pkg::code_a, ship_pkg::code_left:
				if (exp_x > 0)
					exp_x--;
			ship_pkg::code_d, ship_pkg::code_right:
				if (exp_x < ship_pkg::screen_w - 1)
					exp_x++;
			ship_pkg::code_w, ship_pkg::code_up:
				if (exp_y > 0)
					exp_y--; // row 0 on top
			ship_pkg::code_s, ship_pkg::code_down:
				if (exp_y < ship_pkg::screen_h - 1)
					exp_y++;
			default:
				exp_x = exp_x; // no move
		endcase
	endtask

	function automatic bit is_move_code(input ship_pkg::scan_code_t code);
		case (code)
			ship_pkg::code_a, ship_pkg::code_d, ship_pkg::code_s, ship_pkg::code_w,
			ship_pkg::code_up, ship_pkg::code_left, ship_pkg::code_down,
			ship_pkg::code_right:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	task automatic press_key(input ship_pkg::scan_code_t code);
		send_byte(code);                 // make
		send_byte(ship_pkg::code_break);
		send_byte(code);                 // release, must be dropped
		model_key(code);
	endtask

	// outputs sampled on the falling edge, away from register updates
	task automatic wait_frame_start(output bit found);
		int wait_cnt;
		wait_cnt = 0;
		@(negedge clock);
		while (!(plot && pixel_x == 0 && pixel_y == 0) && wait_cnt < 2 * frame_len)
		begin
			@(negedge clock);
			wait_cnt++;
		end
		found = (wait_cnt < 2 * frame_len);
		if (!found)
		begin
			errors++;
			$display("frame start at pixel 0,0 never came within two frames");
		end
	endtask

	task automatic find_ship();
		bit found;
		white_count = 0;
		white_x     = -1; // stays all ones if nothing white
		white_y     = -1;
		plot_low    = 0;
		wait_frame_start(found);
		if (found)
			for (int i = 0; i < frame_len; i++)
			begin
				if (!plot)
					plot_low++;
				if (colour == ship_pkg::colour_white)
				begin
					white_count++;
					white_x = pixel_x;
					white_y = pixel_y;
				end
				@(negedge clock);
			end
	endtask

	task automatic verify_ship();
		find_ship();
		check("white pixel count", white_count, 1);
		check("pixel_x of ship", white_x, exp_x);
		check("pixel_y of ship", white_y, exp_y);
	endtask

	task automatic finish_test(input int num, input string name);
		if (errors == test_errors)
			$display("test %0d %s: ok", num, name);
		else
			$display("test %0d %s: %0d errors", num, name, errors - test_errors);
		test_errors = errors;
	endtask

	task automatic test_reset_position();
		exp_x = 80;
		exp_y = 60;
		verify_ship();
		check("plot low samples", plot_low, 0); // plot stays high
	endtask

	task automatic test_make_release();
		press_key(ship_pkg::code_d); // one step right only
		verify_ship();
	endtask

	task automatic test_all_directions();
		ship_pkg::scan_code_t keys [7];
		keys = '{ship_pkg::code_w, ship_pkg::code_a, ship_pkg::code_s, ship_pkg::code_right,
			ship_pkg::code_up, ship_pkg::code_left, ship_pkg::code_down};
		foreach (keys[i])
		begin
			press_key(keys[i]);
			verify_ship();
		end
	endtask

	task automatic test_edge_clamp();
		repeat (85) press_key(ship_pkg::code_a); // more than the distance to x = 0
		verify_ship();
		check("pixel_x at left edge", white_x, 0);
		repeat (65) press_key(ship_pkg::code_up);
		verify_ship();
		check("pixel_y at top edge", white_y, 0);
	endtask

	task automatic test_ignored_codes();
		ship_pkg::scan_code_t code;
		press_key(8'h29); // space
		verify_ship();
		repeat (4)
		begin
			code = 8'($random(seed));
			while (is_move_code(code) || code == ship_pkg::code_break)
				code = 8'($random(seed));
			press_key(code); // unknown, no move
			verify_ship();
		end
		send_byte(ship_pkg::code_s); // lone make, never released
		model_key(ship_pkg::code_s);
		verify_ship();
	endtask

	task automatic test_raster_order();
		bit found;
		int len;
		int px;
		int py;
		int nx;
		int ny;
		wait_frame_start(found);
		if (found)
		begin
			px  = 0;
			py  = 0;
			len = 1;
			@(negedge clock);
			// loop bound doubles as the timeout
			while (!(pixel_x == 0 && pixel_y == 0) && len <= frame_len && errors == test_errors)
			begin
				nx = (px == ship_pkg::screen_w - 1) ? 0 : px + 1;
				ny = (px != ship_pkg::screen_w - 1) ? py : (py == ship_pkg::screen_h - 1) ? 0 : py + 1;
				check("pixel_x", pixel_x, nx);
				check("pixel_y", pixel_y, ny);
				px = pixel_x;
				py = pixel_y;
				len++;
				@(negedge clock);
			end
			check("last pixel_x of frame", px, ship_pkg::screen_w - 1); // wrap point
			check("last pixel_y of frame", py, ship_pkg::screen_h - 1);
			check("frame length", len, frame_len);
		end
	endtask

	initial
	begin
		errors      = 0;
		checks      = 0;
		test_errors = 0;
		reset       = 1'b1;
		ps2_clk     = 1'b1; // keyboard bus idles high
		ps2_data    = 1'b1;
		repeat (2) @(posedge clock);
		reset <= 1'b0;
		repeat (16) @(posedge clock); // clock filter settles on idle level
		test_reset_position();
		finish_test(1, "reset position");
		test_make_release();
		finish_test(2, "make and release");
		test_all_directions();
		finish_test(3, "all directions");
		test_edge_clamp();
		finish_test(4, "edge clamp");
		test_ignored_codes();
		finish_test(5, "ignored codes");
		test_raster_order();
		finish_test(6, "raster order");
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

//--- ship_game.sv
// keyboard driven ship game top
`timescale 1ns/1ps

module ship_game #(
	parameter int           FILTER_LEN = 8,     // keyboard clock filter depth
	parameter ship_pkg::x_t START_X    = 8'd80, // reset column
	parameter ship_pkg::y_t START_Y    = 7'd60  // reset row
) (
	input  logic              clock,
	input  logic              reset,
	input  logic              ps2_clk,
	input  logic              ps2_data,
	output ship_pkg::x_t      pixel_x,
	output ship_pkg::y_t      pixel_y,
	output ship_pkg::colour_t colour,
	output logic              plot
);

	ship_pkg::scan_code_t rx_code;   // every received byte
	logic                 rx_done;
	ship_pkg::scan_code_t key_code;  // make codes only
	logic                 key_valid;
	ship_pkg::x_t         ship_x;    // current ship position
	ship_pkg::y_t         ship_y;

	ps2_rx #(.FILTER_LEN(FILTER_LEN)) ps2_rx_inst (
		.clock    (clock),
		.reset    (reset),
		.ps2_clk  (ps2_clk),
		.ps2_data (ps2_data),
		.rx_code  (rx_code),
		.rx_done  (rx_done)
	);

	make_break_filter make_break_filter_inst (
		.clock     (clock),
		.reset     (reset),
		.rx_code   (rx_code),
		.rx_done   (rx_done),
		.key_code  (key_code),
		.key_valid (key_valid)
	);

	ship_motion #(.START_X(START_X), .START_Y(START_Y)) ship_motion_inst (
		.clock     (clock),
		.reset     (reset),
		.key_code  (key_code),
		.key_valid (key_valid),
		.ship_x    (ship_x),
		.ship_y    (ship_y)
	);

	raster_draw raster_draw_inst (
		.clock   (clock),
		.reset   (reset),
		.ship_x  (ship_x),
		.ship_y  (ship_y),
		.pixel_x (pixel_x),
		.pixel_y (pixel_y),
		.colour  (colour),
		.plot    (plot)
	);

endmodule

//--- raster_draw.sv
// raster scan pixel writer
`timescale 1ns/1ps

module raster_draw (
	input  logic              clock,
	input  logic              reset,
	input  ship_pkg::x_t      ship_x,
	input  ship_pkg::y_t      ship_y,
	output ship_pkg::x_t      pixel_x, // pixel being written
	output ship_pkg::y_t      pixel_y,
	output ship_pkg::colour_t colour,  // colour of that pixel
	output logic              plot     // write strobe, high after reset
);

	localparam ship_pkg::x_t x_last = ship_pkg::x_t'(ship_pkg::screen_w - 1);
	localparam ship_pkg::y_t y_last = ship_pkg::y_t'(ship_pkg::screen_h - 1);

	ship_pkg::x_t scan_x; // row-major counter
	ship_pkg::y_t scan_y;

	// walk every pixel, wrap at the last column and last row
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			scan_x <= '0;
			scan_y <= '0;
		end
		else if (scan_x == x_last)
		begin
			scan_x <= '0;
			if (scan_y == y_last)
				scan_y <= '0; // next frame
			else
				scan_y <= scan_y + 1'b1;
		end
		else
			scan_x <= scan_x + 1'b1;
	end

	// coordinates and colour registered together
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			pixel_x <= '0;
			pixel_y <= '0;
			colour  <= ship_pkg::colour_black;
			plot    <= 1'b0;
		end
		else
		begin
			pixel_x <= scan_x;
			pixel_y <= scan_y;
			if (scan_x == ship_x && scan_y == ship_y)
				colour <= ship_pkg::colour_white; // ship pixel
			else
				colour <= ship_pkg::colour_black;
			plot <= 1'b1; // every pixel is written
		end
	end

	a_in_bounds: assert property (@(posedge clock) disable iff (reset)
		plot |-> pixel_x < ship_pkg::screen_w && pixel_y < ship_pkg::screen_h)
		else $error("pixel off screen at %0d,%0d", pixel_x, pixel_y);

endmodule

//--- ship_motion.sv
// ship position from key presses
`timescale 1ns/1ps

module ship_motion #(
	parameter ship_pkg::x_t START_X = 8'd80, // column after reset
	parameter ship_pkg::y_t START_Y = 7'd60  // row after reset
) (
	input  logic                 clock,
	input  logic                 reset,
	input  ship_pkg::scan_code_t key_code,
	input  logic                 key_valid, // one move per strobe
	output ship_pkg::x_t         ship_x,
	output ship_pkg::y_t         ship_y
);

	localparam ship_pkg::x_t x_max = ship_pkg::x_t'(ship_pkg::screen_w - 1); // 159
	localparam ship_pkg::y_t y_max = ship_pkg::y_t'(ship_pkg::screen_h - 1); // 119

	ship_pkg::move_t move; // decoded key

	// wasd and arrows share a move
	always_comb
	begin
		case (key_code)
			ship_pkg::code_a, ship_pkg::code_left:
				move = ship_pkg::move_left;
			ship_pkg::code_d, ship_pkg::code_right:
				move = ship_pkg::move_right;
			ship_pkg::code_w, ship_pkg::code_up:
				move = ship_pkg::move_up;
			ship_pkg::code_s, ship_pkg::code_down:
				move = ship_pkg::move_down;
			default:
				move = ship_pkg::move_none; // space, e0, anything else
		endcase
	end

	// step one pixel, clamp at the edges
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			ship_x <= START_X;
			ship_y <= START_Y;
		end
		else if (key_valid)
		begin
			case (move)
				ship_pkg::move_left:
					if (ship_x != '0)
						ship_x <= ship_x - 1'b1;
				ship_pkg::move_right:
					if (ship_x < x_max)
						ship_x <= ship_x + 1'b1;
				ship_pkg::move_up:
					if (ship_y != '0) // top row is 0
						ship_y <= ship_y - 1'b1;
				ship_pkg::move_down:
					if (ship_y < y_max)
						ship_y <= ship_y + 1'b1;
				default:
				begin
					ship_x <= ship_x; // unknown key, stay
					ship_y <= ship_y;
				end
			endcase
		end
	end

	// clamp keeps the ship on the visible screen
	a_on_screen: assert property (@(posedge clock) disable iff (reset)
		ship_x < ship_pkg::screen_w && ship_y < ship_pkg::screen_h)
		else $error("ship off screen at %0d,%0d", ship_x, ship_y);

endmodule

//--- make_break_filter.sv
// make/break scan code filter
`timescale 1ns/1ps

module make_break_filter (
	input  logic                 clock,
	input  logic                 reset,
	input  ship_pkg::scan_code_t rx_code,   // byte from receiver
	input  logic                 rx_done,   // byte strobe
	output ship_pkg::scan_code_t key_code,  // make code only
	output logic                 key_valid  // one cycle after rx_done
);

	typedef enum logic
	{
		st_pass, // forward make codes
		st_skip  // drop the byte after f0
	} state_t;

	state_t state;
	logic forward; // this byte goes out as a key

	// break prefix itself never goes out
	assign forward = rx_done && (state == st_pass) && (rx_code != ship_pkg::code_break);

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state     <= st_pass;
			key_valid <= 1'b0;
		end
		else
		begin
			key_valid <= forward; // strobe, one clock late
			if (rx_done)
			begin
				case (state)
					st_pass:
						if (rx_code == ship_pkg::code_break)
							state <= st_skip; // release follows
					st_skip:
						state <= st_pass; // released key consumed
				endcase
			end
		end
	end

	// code register, only loaded with a forwarded byte
	always_ff @(posedge clock)
	begin
		if (forward)
			key_code <= rx_code;
	end

	// every key strobe comes from a received byte one cycle earlier
	a_no_break_out: assert property (@(posedge clock) disable iff (reset)
		key_valid |-> $past(rx_done) && key_code != ship_pkg::code_break)
		else $error("key_valid with break code or without a received byte");

endmodule

//--- ps2_rx.sv
// ps2 keyboard frame receiver
`timescale 1ns/1ps

module ps2_rx #(
	parameter int FILTER_LEN = 8 // keyboard clock samples that must agree
) (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 ps2_clk,  // raw keyboard clock
	input  logic                 ps2_data, // raw keyboard data
	output ship_pkg::scan_code_t rx_code,  // data bits of the last frame
	output logic                 rx_done   // one cycle, frame complete
);

	typedef enum logic
	{
		st_idle,      // waiting for start bit edge
		st_receiving  // shifting data, parity, stop
	} state_t;

	state_t state_reg, state_next;
	logic [FILTER_LEN-1:0] filter_reg; // recent ps2_clk samples, newest at msb
	logic clk_level;                   // cleaned keyboard clock
	logic clk_level_next;
	logic fall;                        // falling edge of cleaned clock
	logic [3:0] bits_left, bits_left_next; // edges still expected
	logic [10:0] frame_reg, frame_next;    // shifted in lsb first

	// cleaned level flips only once the whole window agrees
	always_comb
	begin
		if (&filter_reg)
			clk_level_next = 1'b1;
		else if (~|filter_reg)
			clk_level_next = 1'b0;
		else
			clk_level_next = clk_level; // mixed samples, hold
	end

	assign fall = clk_level & ~clk_level_next;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			filter_reg <= '0;
			clk_level  <= 1'b0; // idle-high clock shows up as a rise, not a fall
		end
		else
		begin
			filter_reg <= {ps2_clk, filter_reg[FILTER_LEN-1:1]};
			clk_level  <= clk_level_next;
		end
	end

	// frame FSM
	always_comb
	begin
		state_next     = state_reg;
		bits_left_next = bits_left;
		frame_next     = frame_reg;
		rx_done        = 1'b0;
		case (state_reg)
			st_idle:
				if (fall) // start bit, not stored
				begin
					bits_left_next = 4'd10; // 8 data + parity + stop
					state_next     = st_receiving;
				end
			st_receiving:
			begin
				if (fall)
				begin
					frame_next     = {ps2_data, frame_reg[10:1]}; // right shift
					bits_left_next = bits_left - 4'd1;
				end
				if (bits_left == 4'd0) // stop bit already in
				begin
					rx_done    = 1'b1;
					state_next = st_idle;
				end
			end
		endcase
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state_reg <= st_idle;
			bits_left <= 4'd0;
		end
		else
		begin
			state_reg <= state_next;
			bits_left <= bits_left_next;
		end
	end

	always_ff @(posedge clock)
		frame_reg <= frame_next;

	// after ten shifts data sits in 8:1, parity in 9, stop in 10
	assign rx_code = frame_reg[8:1];

	// done is a strobe, the FSM leaves receiving on the same cycle
	a_done_single: assert property (@(posedge clock) disable iff (reset)
		rx_done |=> !rx_done)
		else $error("rx_done high for two cycles");

endmodule

//--- ship_pkg.sv
// ship game shared definitions
package ship_pkg;

	// screen geometry
	localparam int screen_w = 160; // pixels per row
	localparam int screen_h = 120; // rows per frame

	// coordinates and payload widths
	typedef logic [7:0] x_t;         // column, 0 to 159
	typedef logic [6:0] y_t;         // row, 0 to 119
	typedef logic [7:0] scan_code_t; // one ps2 byte
	typedef logic [2:0] colour_t;    // r, g, b one bit each

	localparam colour_t colour_white = 3'b111; // ship
	localparam colour_t colour_black = 3'b000; // background

	// keyboard sends f0 ahead of the code of a released key
	localparam scan_code_t code_break = 8'hf0;

	// wasd make codes
	localparam scan_code_t code_a = 8'h1c;
	localparam scan_code_t code_d = 8'h23;
	localparam scan_code_t code_s = 8'h1b;
	localparam scan_code_t code_w = 8'h1d;

	// arrow keys, extended set
	// the e0 prefix in front of them decodes as an unknown code
	localparam scan_code_t code_up    = 8'h75;
	localparam scan_code_t code_left  = 8'h6b;
	localparam scan_code_t code_down  = 8'h72;
	localparam scan_code_t code_right = 8'h74;

	// one-pixel step requested by a key
	typedef enum logic [2:0]
	{
		move_none,  // unknown key
		move_left,  // x - 1
		move_right, // x + 1
		move_up,    // y - 1, row 0 is the top
		move_down   // y + 1
	} move_t;

endpackage
